// File: project.f
logic/trig_pkg.sv
logic/axil_csr_decode.sv
logic/trigger_or_tree.sv
logic/hit_scaler_bank.sv
logic/output_shaper.sv
logic/trig_top.sv
dv/tb_checker.sv
dv/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench, the log decides pass or fail
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_top \
	-o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb 2>&1 | tee sim.log \
	|| { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

! grep -q "RESULT: FAIL" sim.log && grep -q "RESULT: PASS" sim.log \
	|| { echo "simulation reported failure"; exit 1; }

// File: dv/tb_top.sv
`default_nettype none

module tb_top;

	import trig_pkg::*;

	localparam int cycle_limit = 4000;

	logic CLK200;
	logic tdc_reset_start;
	logic [num_channels-1:0] hits;
	logic busy_in;
	logic awvalid;
	logic [axil_addr_width-1:0] awaddr;
	logic wvalid;
	logic [axil_data_width-1:0] wdata;
	logic bready;
	logic arvalid;
	logic [axil_addr_width-1:0] araddr;
	logic rready;
	logic awready;
	logic wready;
	logic bvalid;
	logic [1:0] bresp;
	logic arready;
	logic rvalid;
	logic [axil_data_width-1:0] rdata;
	logic [1:0] rresp;
	logic [num_triggers-1:0] trig_out;
	int mismatch_count;
	int other_count;
	int tb_errors;
	int cycle_count;
	logic [15:0] lfsr_state;

	trig_top u_dut (.*);

	tb_checker u_checker (.*);

	initial begin
		CLK200 = 1'b0;
		forever #50 CLK200 = ~CLK200;
	end

	// run limit, about twice the stimulus length
	always @(posedge CLK200) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: stimulus did not finish within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// ----------------------------------------
	// random numbers
	// ----------------------------------------

	// fibonacci lfsr x^16+x^14+x^13+x^11, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// ----------------------------------------
	// bus and hit tasks
	// ----------------------------------------

	task automatic axi_write(input logic [7:0] a, input logic [31:0] d, input int stall);
		int n;
		@(posedge CLK200);
		awvalid <= 1'b1;
		awaddr <= a;
		wvalid <= 1'b1;
		wdata <= d;
		bready <= 1'b0;
		n = 0;
		do begin
			@(posedge CLK200);
			n++;
		end while (!awready && n < 50);
		if (!awready) begin
			$display("write to address %h was never accepted", a);
			tb_errors++;
		end
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		repeat (stall) @(posedge CLK200);
		bready <= 1'b1;
		n = 0;
		do begin
			@(posedge CLK200);
			n++;
		end while (!bvalid && n < 50);
		if (!bvalid) begin
			$display("write to address %h got no response", a);
			tb_errors++;
		end
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] a, input int stall);
		int n;
		@(posedge CLK200);
		arvalid <= 1'b1;
		araddr <= a;
		rready <= 1'b0;
		n = 0;
		do begin
			@(posedge CLK200);
			n++;
		end while (!arready && n < 50);
		if (!arready) begin
			$display("read of address %h was never accepted", a);
			tb_errors++;
		end
		arvalid <= 1'b0;
		repeat (stall) @(posedge CLK200);
		rready <= 1'b1;
		n = 0;
		do begin
			@(posedge CLK200);
			n++;
		end while (!rvalid && n < 50);
		if (!rvalid) begin
			$display("read of address %h got no response", a);
			tb_errors++;
		end
		rready <= 1'b0;
	endtask

	task automatic pulse_hit(input int ch);
		@(posedge CLK200);
		hits <= 24'(1) << ch;
		@(posedge CLK200);
		hits <= '0;
	endtask

	// random single hits, busy toggles now and then when asked
	task automatic run_hits(input int cycles, input logic with_busy);
		repeat (cycles) begin
			@(posedge CLK200);
			hits <= take_bits(1) ? 24'(1) << (take_bits(5) % num_channels) : '0;
			if (with_busy && take_bits(3) == 0) begin
				busy_in <= !busy_in;
			end
		end
		@(posedge CLK200);
		hits <= '0;
		busy_in <= 1'b0;
	endtask

	task automatic command(input cmd_bit_e b);
		axi_write(addr_command, 32'(1) << b, 0);
	endtask

	task automatic read_counts();
		axi_read(addr_clock, 0);
		for (int k = 0; k < num_channels; k++) begin
			axi_read(addr_scaler_base + 8'(4 * k), int'(take_bits(2)));
		end
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------

	initial begin
		lfsr_state = 16'd7;
		tb_errors = 0;
		cycle_count = 0;
		tdc_reset_start = 1'b1;
		hits = '0;
		busy_in = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		repeat (3) @(posedge CLK200);
		tdc_reset_start <= 1'b0;

		// register access and error responses
		axi_write(addr_config, 32'habcd_2395, 0);
		axi_read(addr_config, 0);
		axi_read(addr_info, 0);
		axi_read(8'h20, 0);
		axi_read(8'h42, 0);
		axi_read(8'ha0, 0);
		axi_read(addr_command, 0);
		axi_write(8'h24, 32'h1, 0);
		axi_write(addr_info, 32'hffff_ffff, 0);
		// config must be untouched by the refused writes
		axi_read(addr_config, 0);

		// routing with random group masks
		for (int i = 0; i < 8; i++) begin
			axi_write(addr_config, {16'h0, 4'd1, 4'd2, 2'b00, 6'(take_bits(6))}, 0);
			pulse_hit(int'(take_bits(5) % num_channels));
			repeat (12) @(posedge CLK200);
		end

		// shaping, merged hits, then one after the dead time
		axi_write(addr_config, 32'h0000_343f, 0);
		pulse_hit(0);
		pulse_hit(9);
		repeat (3) @(posedge CLK200);
		pulse_hit(17);
		repeat (15) @(posedge CLK200);
		pulse_hit(3);
		repeat (12) @(posedge CLK200);
		// long pulse cut short by the output reset
		axi_write(addr_config, 32'h0000_0f3f, 0);
		pulse_hit(5);
		repeat (4) @(posedge CLK200);
		command(cmd_output_reset);
		repeat (20) @(posedge CLK200);

		// scalers without busy gating
		axi_write(addr_config, 32'h0000_343f, 0);
		command(cmd_counter_reset);
		run_hits(200, 1'b0);
		command(cmd_counter_latch);
		read_counts();

		// stop counting on busy, then busy ignored
		axi_write(addr_config, 32'h0000_347f, 0);
		command(cmd_counter_reset);
		run_hits(200, 1'b1);
		command(cmd_counter_latch);
		read_counts();
		axi_write(addr_config, 32'h0000_343f, 0);
		command(cmd_counter_reset);
		run_hits(100, 1'b1);
		command(cmd_counter_latch);
		read_counts();

		// back-pressure on both response channels
		for (int i = 0; i < 6; i++) begin
			axi_write(addr_config, {16'h0, 4'd2, 4'd3, 2'b00, 6'(take_bits(6))},
				int'(take_bits(3)));
			axi_read(addr_config, int'(take_bits(3)));
			axi_read(addr_scaler_base + 8'(4 * (take_bits(5) % num_channels)),
				int'(take_bits(3)));
		end

		repeat (10) @(posedge CLK200);
		$display("errors: %0d mismatches, %0d other", mismatch_count,
			other_count + tb_errors);
		if (mismatch_count == 0 && other_count == 0 && tb_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/tb_checker.sv
`default_nettype none

module tb_checker (
	input logic CLK200,
	input logic tdc_reset_start,
	input logic [trig_pkg::num_channels-1:0] hits,
	input logic busy_in,
	input logic awvalid,
	input logic [trig_pkg::axil_addr_width-1:0] awaddr,
	input logic wvalid,
	input logic [trig_pkg::axil_data_width-1:0] wdata,
	input logic awready,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input logic [1:0] bresp,
	input logic arvalid,
	input logic [trig_pkg::axil_addr_width-1:0] araddr,
	input logic arready,
	input logic rvalid,
	input logic rready,
	input logic [trig_pkg::axil_data_width-1:0] rdata,
	input logic [1:0] rresp,
	input logic [trig_pkg::num_triggers-1:0] trig_out,
	output int mismatch_count,
	output int other_count
);

	import trig_pkg::*;

	// model of the register file
	logic armed;
	logic [15:0] cfg_m;
	logic [2:0] cmd_m;
	logic [1:0] exp_bresp;
	logic [1:0] exp_rresp;
	logic [31:0] exp_rdata;
	logic bwait_q;
	logic rwait_q;
	// model of the or tree, one variable per pipeline step
	logic [num_channels-1:0] tree_hits;
	logic [num_groups-1:0] tree_groups;
	logic [num_triggers-1:0][num_groups-1:0] tree_sel;
	logic [num_triggers-1:0] tree_line;
	logic [num_triggers-1:0] line_new;
	// model of the shapers
	shaper_state_e sh_st [num_triggers];
	int sh_cnt [num_triggers];
	logic [num_triggers-1:0] pulse_m;
	// model of the scalers
	logic busy_m;
	logic [num_channels-1:0] cnt_hits;
	logic [31:0] cnt_m [num_channels];
	logic [31:0] lat_m [num_channels];
	logic [31:0] clk_m;
	logic [31:0] clat_m;

	initial begin
		mismatch_count = 0;
		other_count = 0;
		armed = 1'b0;
	end

	// ----------------------------------------
	// reference functions
	// ----------------------------------------

	// one bit per group of eight channels
	function automatic logic [num_groups-1:0] group_hits(input logic [num_channels-1:0] h);
		logic [num_groups-1:0] g;
		for (int i = 0; i < num_groups; i++) begin
			g[i] = |h[i*channels_per_group +: channels_per_group];
		end
		return g;
	endfunction

	// expected read data and response from the model state
	function void expect_read(input logic [7:0] a, output logic [31:0] d, output logic [1:0] r);
		d = '0;
		r = resp_okay;
		if (a == 8'h00) begin
			d = {16'h0000, cfg_m};
		end else if (a == 8'h08) begin
			d = clat_m;
		end else if (a == 8'h0c) begin
			d = 32'h0000_1822;
		end else if (a >= 8'h40 && a[1:0] == 2'b00 && (a - 8'h40) / 4 < num_channels) begin
			d = lat_m[(a - 8'h40) / 4];
		end else begin
			r = resp_slverr;
		end
	endfunction

	// pulse for max(high,1) cycles, then dead time with input ignored
	task automatic step_shaper(input int t, input logic line, input logic [3:0] ht,
			input logic [3:0] dt, input logic orst);
		if (orst) begin
			sh_st[t] = sh_idle;
			pulse_m[t] = 1'b0;
		end else begin
			case (sh_st[t])
				sh_idle: begin
					if (line) begin
						sh_st[t] = sh_high;
						pulse_m[t] = 1'b1;
						sh_cnt[t] = (ht == 0) ? 1 : int'(ht);
					end
				end
				sh_high: begin
					if (sh_cnt[t] <= 1) begin
						pulse_m[t] = 1'b0;
						sh_st[t] = (dt == 0) ? sh_idle : sh_dead;
						sh_cnt[t] = int'(dt);
					end else begin
						sh_cnt[t]--;
					end
				end
				default: begin
					if (sh_cnt[t] <= 1) begin
						sh_st[t] = sh_idle;
					end else begin
						sh_cnt[t]--;
					end
				end
			endcase
		end
	endtask

	// ----------------------------------------
	// compare and step the model
	// ----------------------------------------

	always @(posedge CLK200) begin
		if (tdc_reset_start) begin
			armed = 1'b1;
			cfg_m = '0;
			cmd_m = '0;
			exp_bresp = resp_okay;
			exp_rresp = resp_okay;
			exp_rdata = '0;
			bwait_q = 1'b0;
			rwait_q = 1'b0;
			tree_hits = '0;
			tree_groups = '0;
			tree_sel = '0;
			tree_line = '0;
			pulse_m = '0;
			busy_m = 1'b0;
			cnt_hits = '0;
			clk_m = '0;
			clat_m = '0;
			for (int t = 0; t < num_triggers; t++) begin
				sh_st[t] = sh_idle;
				sh_cnt[t] = 0;
			end
			for (int k = 0; k < num_channels; k++) begin
				cnt_m[k] = '0;
				lat_m[k] = '0;
			end
		end else if (armed) begin
			if (trig_out !== pulse_m) begin
				$display("mismatch trig_out: got %h expected %h", trig_out, pulse_m);
				mismatch_count++;
			end
			// held responses are compared every cycle they wait
			if (bvalid && bresp !== exp_bresp) begin
				$display("mismatch bresp: got %h expected %h", bresp, exp_bresp);
				mismatch_count++;
			end
			if (rvalid && (rdata !== exp_rdata || rresp !== exp_rresp)) begin
				$display("mismatch rdata/rresp: got %h/%h expected %h/%h",
					rdata, rresp, exp_rdata, exp_rresp);
				mismatch_count++;
			end
			if (bwait_q && !bvalid) begin
				$display("write response was withdrawn before bready");
				other_count++;
			end
			if (rwait_q && !rvalid) begin
				$display("read response was withdrawn before rready");
				other_count++;
			end
			bwait_q = bvalid && !bready;
			rwait_q = rvalid && !rready;
			if (arvalid && arready) begin
				expect_read(araddr, exp_rdata, exp_rresp);
			end

			// scalers, command pulses act in the cycle after the write
			for (int k = 0; k < num_channels; k++) begin
				if (cmd_m[cmd_counter_reset]) begin
					cnt_m[k] = '0;
				end else if (cnt_hits[k] && !busy_m) begin
					cnt_m[k] = cnt_m[k] + 1;
				end
				if (cmd_m[cmd_counter_latch]) begin
					lat_m[k] = cnt_m[k];
				end
			end
			if (cmd_m[cmd_counter_reset]) begin
				clk_m = '0;
			end else if (!busy_m) begin
				clk_m = clk_m + 1;
			end
			if (cmd_m[cmd_counter_latch]) begin
				clat_m = clk_m;
			end
			cnt_hits = hits;
			busy_m = busy_in && cfg_m[6];

			// or tree, four steps from hits to trigger line
			for (int t = 0; t < num_triggers; t++) begin
				line_new[t] = |tree_sel[t];
			end
			tree_sel[0] = tree_groups & cfg_m[2:0];
			tree_sel[1] = tree_groups & cfg_m[5:3];
			tree_groups = group_hits(tree_hits);
			tree_hits = hits;
			for (int t = 0; t < num_triggers; t++) begin
				step_shaper(t, tree_line[t], cfg_m[11:8], cfg_m[15:12],
					cmd_m[cmd_output_reset]);
			end
			tree_line = line_new;

			// accepted write updates the model last
			cmd_m = '0;
			if (awvalid && awready && wvalid && wready) begin
				exp_bresp = (awaddr == 8'h00 || awaddr == 8'h04) ? resp_okay : resp_slverr;
				if (awaddr == 8'h00) begin
					// bit 7 is not implemented
					cfg_m = wdata[15:0] & 16'hff7f;
				end
				if (awaddr == 8'h04) begin
					cmd_m = wdata[2:0];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/trig_top.sv
`default_nettype none

module trig_top (
	input logic CLK200,
	input logic tdc_reset_start,
	input logic [trig_pkg::num_channels-1:0] hits,
	input logic busy_in,
	input logic awvalid,
	input logic [trig_pkg::axil_addr_width-1:0] awaddr,
	input logic wvalid,
	input logic [trig_pkg::axil_data_width-1:0] wdata,
	input logic bready,
	input logic arvalid,
	input logic [trig_pkg::axil_addr_width-1:0] araddr,
	input logic rready,
	output logic awready,
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp,
	output logic arready,
	output logic rvalid,
	output logic [trig_pkg::axil_data_width-1:0] rdata,
	output logic [1:0] rresp,
	output logic [trig_pkg::num_triggers-1:0] trig_out
);

	import trig_pkg::*;

	// config and command lines from the register file
	logic [num_groups-1:0] trig_mask_0;
	logic [num_groups-1:0] trig_mask_1;
	logic stop_on_busy;
	logic [time_width-1:0] high_time;
	logic [time_width-1:0] dead_time;
	logic counter_reset;
	logic counter_latch;
	logic output_reset;
	// scaler snapshots for readback
	logic [count_width-1:0] clock_latched;
	logic [num_channels-1:0][count_width-1:0] scaler_latched;
	// unshaped trigger lines
	logic [num_triggers-1:0] trig_line;

	// ----------------------------------------
	// register file, tree and scalers
	// ----------------------------------------

	axil_csr_decode u_csr (.*);

	trigger_or_tree u_tree (.*);

	hit_scaler_bank u_scalers (.*);

	// ----------------------------------------
	// shaped trigger outputs
	// ----------------------------------------

	output_shaper u_shaper_0 (
		.CLK200(CLK200),
		.tdc_reset_start(tdc_reset_start),
		.trig_line(trig_line[0]),
		.high_time(high_time),
		.dead_time(dead_time),
		.output_reset(output_reset),
		.pulse(trig_out[0])
	);

	output_shaper u_shaper_1 (
		.CLK200(CLK200),
		.tdc_reset_start(tdc_reset_start),
		.trig_line(trig_line[1]),
		.high_time(high_time),
		.dead_time(dead_time),
		.output_reset(output_reset),
		.pulse(trig_out[1])
	);

endmodule

`default_nettype wire

// File: logic/output_shaper.sv
`default_nettype none

module output_shaper (
	input logic CLK200,
	input logic tdc_reset_start,
	input logic trig_line,
	input logic [trig_pkg::time_width-1:0] high_time,
	input logic [trig_pkg::time_width-1:0] dead_time,
	input logic output_reset,
	output logic pulse
);

	import trig_pkg::*;

	shaper_state_e state;
	// cycles left in the current high or dead phase, minus one
	logic [time_width-1:0] remaining;

	always_ff @(posedge CLK200) begin
		if (tdc_reset_start || output_reset) begin
			state <= sh_idle;
			pulse <= 1'b0;
			remaining <= '0;
		end else begin
			unique case (state)
				sh_idle: begin
					if (trig_line) begin
						state <= sh_high;
						pulse <= 1'b1;
						// zero high time still gives one cycle
						remaining <= (high_time == '0) ? '0 : high_time - 1'b1;
					end
				end
				sh_high: begin
					// input ignored, later triggers merge into this pulse
					if (remaining == '0) begin
						pulse <= 1'b0;
						if (dead_time == '0) begin
							state <= sh_idle;
						end else begin
							state <= sh_dead;
							remaining <= dead_time - 1'b1;
						end
					end else begin
						remaining <= remaining - 1'b1;
					end
				end
				sh_dead: begin
					if (remaining == '0) begin
						state <= sh_idle;
					end else begin
						remaining <= remaining - 1'b1;
					end
				end
				default: begin
					state <= sh_idle;
					pulse <= 1'b0;
				end
			endcase
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------

	a_pulse_only_high: assert property (@(posedge CLK200) disable iff (tdc_reset_start)
		pulse |-> state == sh_high);

endmodule

`default_nettype wire

// File: logic/hit_scaler_bank.sv
`default_nettype none

module hit_scaler_bank (
	input logic CLK200,
	input logic tdc_reset_start,
	input logic [trig_pkg::num_channels-1:0] hits,
	input logic busy_in,
	input logic stop_on_busy,
	input logic counter_reset,
	input logic counter_latch,
	output logic [trig_pkg::num_channels-1:0][trig_pkg::count_width-1:0] scaler_latched,
	output logic [trig_pkg::count_width-1:0] clock_latched
);

	import trig_pkg::*;

	logic busy_gated;
	logic [num_channels-1:0] hits_q;
	logic [num_channels-1:0][count_width-1:0] hit_count;
	logic [num_channels-1:0][count_width-1:0] hit_count_next;
	logic [count_width-1:0] clock_count;
	logic [count_width-1:0] clock_count_next;

	// ----------------------------------------
	// busy gate
	// ----------------------------------------

	// hits are delayed by one so they meet the registered busy
	always_ff @(posedge CLK200) begin
		if (tdc_reset_start) begin
			busy_gated <= 1'b0;
			hits_q <= '0;
		end else begin
			busy_gated <= busy_in & stop_on_busy;
			hits_q <= hits;
		end
	end

	// ----------------------------------------
	// counters
	// ----------------------------------------

	// next values, also what a latch in this cycle captures
	always_comb begin
		for (int k = 0; k < num_channels; k++) begin
			if (counter_reset) begin
				hit_count_next[k] = '0;
			end else if (hits_q[k] && !busy_gated) begin
				hit_count_next[k] = hit_count[k] + 1'b1;
			end else begin
				hit_count_next[k] = hit_count[k];
			end
		end
		// reference clock counts every non-busy cycle
		if (counter_reset) begin
			clock_count_next = '0;
		end else if (!busy_gated) begin
			clock_count_next = clock_count + 1'b1;
		end else begin
			clock_count_next = clock_count;
		end
	end

	always_ff @(posedge CLK200) begin
		if (tdc_reset_start) begin
			hit_count <= '0;
			clock_count <= '0;
			scaler_latched <= '0;
			clock_latched <= '0;
		end else begin
			hit_count <= hit_count_next;
			clock_count <= clock_count_next;
			// snapshot for the bus, counting goes on
			if (counter_latch) begin
				scaler_latched <= hit_count_next;
				clock_latched <= clock_count_next;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/trigger_or_tree.sv
`default_nettype none

module trigger_or_tree (
	input logic CLK200,
	input logic tdc_reset_start,
	input logic [trig_pkg::num_channels-1:0] hits,
	input logic [trig_pkg::num_groups-1:0] trig_mask_0,
	input logic [trig_pkg::num_groups-1:0] trig_mask_1,
	output logic [trig_pkg::num_triggers-1:0] trig_line
);

	import trig_pkg::*;

	// one register per stage, patterns follow each other every cycle
	logic [num_clusters-1:0] cluster_or;
	logic [num_groups-1:0] group_or;
	logic [num_triggers-1:0][num_groups-1:0] selected;

	always_ff @(posedge CLK200) begin
		if (tdc_reset_start) begin
			cluster_or <= '0;
			group_or <= '0;
			selected <= '0;
			trig_line <= '0;
		end else begin
			// stage 1 cluster or over four neighbouring hits
			for (int c = 0; c < num_clusters; c++) begin
				cluster_or[c] <= |hits[c*cluster_width +: cluster_width];
			end
			// stage 2 group or over the clusters of one group
			for (int g = 0; g < num_groups; g++) begin
				group_or[g] <= |cluster_or[g*clusters_per_group +: clusters_per_group];
			end
			// stage 3 keep only the groups each trigger listens to
			selected[0] <= group_or & trig_mask_0;
			selected[1] <= group_or & trig_mask_1;
			// stage 4 final or per trigger line
			for (int t = 0; t < num_triggers; t++) begin
				trig_line[t] <= |selected[t];
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/axil_csr_decode.sv
`default_nettype none

module axil_csr_decode (
	input logic CLK200,
	input logic tdc_reset_start,
	input logic awvalid,
	input logic [trig_pkg::axil_addr_width-1:0] awaddr,
	input logic wvalid,
	input logic [trig_pkg::axil_data_width-1:0] wdata,
	input logic bready,
	input logic arvalid,
	input logic [trig_pkg::axil_addr_width-1:0] araddr,
	input logic rready,
	output logic awready,
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp,
	output logic arready,
	output logic rvalid,
	output logic [trig_pkg::axil_data_width-1:0] rdata,
	output logic [1:0] rresp,
	input logic [trig_pkg::count_width-1:0] clock_latched,
	input logic [trig_pkg::num_channels-1:0][trig_pkg::count_width-1:0] scaler_latched,
	output logic [trig_pkg::num_groups-1:0] trig_mask_0,
	output logic [trig_pkg::num_groups-1:0] trig_mask_1,
	output logic stop_on_busy,
	output logic [trig_pkg::time_width-1:0] high_time,
	output logic [trig_pkg::time_width-1:0] dead_time,
	output logic counter_reset,
	output logic counter_latch,
	output logic output_reset
);

	import trig_pkg::*;

	logic wr_ready;
	logic wr_fire;
	logic wr_ok;
	logic rd_fire;
	logic [config_width-1:0] config_reg;
	logic [axil_addr_width-1:0] scaler_offset;
	logic [axil_data_width-1:0] rd_data_next;
	logic [1:0] rd_resp_next;

	// ----------------------------------------
	// config fields
	// ----------------------------------------

	assign trig_mask_0 = config_reg[2:0];
	assign trig_mask_1 = config_reg[5:3];
	assign stop_on_busy = config_reg[6];
	assign high_time = config_reg[11:8];
	assign dead_time = config_reg[15:12];

	// ----------------------------------------
	// write channel
	// ----------------------------------------

	// address and data are taken together, one ready for both
	assign awready = wr_ready;
	assign wready = wr_ready;
	assign wr_fire = awvalid && awready && wvalid && wready;
	// only config and command take writes
	assign wr_ok = (awaddr == addr_config) || (awaddr == addr_command);

	always_ff @(posedge CLK200) begin
		if (tdc_reset_start) begin
			wr_ready <= 1'b0;
			bvalid <= 1'b0;
			config_reg <= '0;
			counter_reset <= 1'b0;
			counter_latch <= 1'b0;
			output_reset <= 1'b0;
		end else begin
			// no new write while a response is still pending
			wr_ready <= awvalid && wvalid && !bvalid && !wr_ready;
			// command strobes last one cycle
			counter_reset <= 1'b0;
			counter_latch <= 1'b0;
			output_reset <= 1'b0;
			if (wr_fire) begin
				bvalid <= 1'b1;
				if (awaddr == addr_config) begin
					config_reg <= wdata[config_width-1:0] & config_write_mask;
				end
				// pulses line up with the rising bvalid
				if (awaddr == addr_command) begin
					counter_reset <= wdata[cmd_counter_reset];
					counter_latch <= wdata[cmd_counter_latch];
					output_reset <= wdata[cmd_output_reset];
				end
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK200) begin
		if (wr_fire) begin
			bresp <= wr_ok ? resp_okay : resp_slverr;
		end
	end

	// ----------------------------------------
	// read channel
	// ----------------------------------------

	assign rd_fire = arvalid && arready;

	// readback mux, anything not listed is an error
	always_comb begin
		rd_data_next = '0;
		rd_resp_next = resp_okay;
		scaler_offset = araddr - addr_scaler_base;
		if (araddr == addr_config) begin
			rd_data_next = {{(axil_data_width - config_width){1'b0}}, config_reg};
		end else if (araddr == addr_clock) begin
			rd_data_next = clock_latched;
		end else if (araddr == addr_info) begin
			rd_data_next = {16'h0000, 8'(num_channels), fw_version};
		end else if (araddr >= addr_scaler_base && scaler_offset[1:0] == 2'b00
				&& scaler_offset[axil_addr_width-1:2] < num_channels) begin
			// word aligned scaler window
			rd_data_next = scaler_latched[scaler_offset[axil_addr_width-1:2]];
		end else begin
			rd_resp_next = resp_slverr;
		end
	end

	always_ff @(posedge CLK200) begin
		if (tdc_reset_start) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			// hold off new addresses under back-pressure
			arready <= arvalid && !rvalid && !arready;
			if (rd_fire) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK200) begin
		if (rd_fire) begin
			rdata <= rd_data_next;
			rresp <= rd_resp_next;
		end
	end

	// ----------------------------------------
	// protocol checks
	// ----------------------------------------

	a_bvalid_hold: assert property (@(posedge CLK200) disable iff (tdc_reset_start)
		bvalid && !bready |=> bvalid && $stable(bresp));

	a_rdata_hold: assert property (@(posedge CLK200) disable iff (tdc_reset_start)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

// File: logic/trig_pkg.sv
`default_nettype none

package trig_pkg;

	// ----------------------------------------
	// sizes
	// ----------------------------------------

	// hit inputs, split evenly into groups
	localparam int num_channels = 24;
	localparam int num_groups = 3;
	localparam int channels_per_group = num_channels / num_groups;
	// first or stage works on clusters of four hits
	localparam int cluster_width = 4;
	localparam int num_clusters = num_channels / cluster_width;
	localparam int clusters_per_group = channels_per_group / cluster_width;
	localparam int num_triggers = 2;
	localparam int count_width = 32;
	localparam int time_width = 4;
	localparam int axil_addr_width = 8;
	localparam int axil_data_width = 32;

	// ----------------------------------------
	// register map
	// ----------------------------------------

	localparam logic [axil_addr_width-1:0] addr_config = 8'h00;
	localparam logic [axil_addr_width-1:0] addr_command = 8'h04;
	localparam logic [axil_addr_width-1:0] addr_clock = 8'h08;
	localparam logic [axil_addr_width-1:0] addr_info = 8'h0c;
	// channel k at base + 4*k
	localparam logic [axil_addr_width-1:0] addr_scaler_base = 8'h40;

	// implemented config bits, bit 7 is a hole
	localparam int config_width = 16;
	localparam logic [config_width-1:0] config_write_mask = 16'hff7f;

	localparam logic [7:0] fw_version = 8'h22;

	// axi response codes
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// bit positions in the command register
	typedef enum int unsigned {
		cmd_counter_reset = 0,
		cmd_counter_latch = 1,
		cmd_output_reset = 2
	} cmd_bit_e;

	// output shaper states
	typedef enum logic [1:0] {
		sh_idle,
		sh_high,
		sh_dead
	} shaper_state_e;

endpackage

`default_nettype wire
